/* logic/byte_ingest.sv */
`timescale 1ns/1ps

module byte_ingest
  import match_pkg::*;
#(
  parameter int NUM_STREAMS = match_pkg::NUM_STREAMS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [7:0]             in_data,
  input  logic                   in_sop,
  input  logic                   in_eop,
  input  logic [STREAM_ID_W-1:0] in_stream_id,
  output logic                   in_ready,
  output logic                   load_state,
  output logic                   load_new,
  output logic [STREAM_ID_W-1:0] load_stream_id,
  output logic                   char_valid,
  output logic [7:0]             char_data,
  output logic                   pkt_end
);

  // BOOT keeps in_ready low until the first cycle after reset
  typedef enum logic [2:0] {
    ST_BOOT,
    ST_IDLE,
    ST_LOAD,
    ST_SCAN,
    ST_DRAIN
  } ingest_state_t;

  ingest_state_t state_q;
  logic [1:0] drain_cnt;
  // Streams that have had at least one packet loaded
  logic [NUM_STREAMS-1:0] seen;
  // sop byte parked across the context load cycle
  logic [7:0] hold_data;
  logic       hold_eop;
  logic       accept;

  // Ready only while waiting for sop or scanning packet bytes
  assign in_ready = (state_q == ST_IDLE) || (state_q == ST_SCAN);
  assign accept   = in_valid && in_ready;

  // Context load request goes out with the sop byte itself
  assign load_state     = (state_q == ST_IDLE) && accept && in_sop;
  assign load_stream_id = in_stream_id;
  assign load_new       = !seen[in_stream_id];

  // Load cycle replays the parked sop byte, scan passes bytes straight on
  assign char_valid = (state_q == ST_LOAD) || ((state_q == ST_SCAN) && in_valid);
  assign char_data  = (state_q == ST_LOAD) ? hold_data : in_data;

  // Third drain cycle, when the last accept has reached the matcher output
  assign pkt_end = (state_q == ST_DRAIN) && (drain_cnt == 2'd2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= ST_BOOT;
      drain_cnt <= 2'd0;
      seen      <= '0;
    end else begin
      case (state_q)
        ST_BOOT: state_q <= ST_IDLE;
        // Bytes outside a packet are dropped
        ST_IDLE: if (load_state) state_q <= ST_LOAD;
        // Single byte packet goes straight to drain
        ST_LOAD: state_q <= hold_eop ? ST_DRAIN : ST_SCAN;
        ST_SCAN: if (accept && in_eop) state_q <= ST_DRAIN;
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'd2)
          begin
            drain_cnt <= 2'd0;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
      // First load marks the stream as known
      if (load_state)
        seen[in_stream_id] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_state)
    begin
      hold_data <= in_data;
      hold_eop  <= in_eop;
    end
  end

endmodule

/* logic/csr_axil.sv */
`timescale 1ns/1ps

module csr_axil
  import match_pkg::*;
  import csr_pkg::*;
#(
  parameter int NUM_STREAMS = match_pkg::NUM_STREAMS
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s_axil_awvalid,
  input  logic [AXIL_ADDR_W-1:0]   s_axil_awaddr,
  output logic                     s_axil_awready,
  input  logic                     s_axil_wvalid,
  input  logic [AXIL_DATA_W-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_W/8-1:0] s_axil_wstrb,
  output logic                     s_axil_wready,
  output logic                     s_axil_bvalid,
  output logic [1:0]               s_axil_bresp,
  input  logic                     s_axil_bready,
  input  logic                     s_axil_arvalid,
  input  logic [AXIL_ADDR_W-1:0]   s_axil_araddr,
  output logic                     s_axil_arready,
  output logic                     s_axil_rvalid,
  output logic [AXIL_DATA_W-1:0]   s_axil_rdata,
  output logic [1:0]               s_axil_rresp,
  input  logic                     s_axil_rready,
  input  logic [CNT_W-1:0]         match_count,
  input  logic [CNT_W-1:0]         pkt_count,
  output logic [NUM_STREAMS-1:0]   enable_mask
);

  // Enable bits as two bus words
  logic [AXIL_DATA_W-1:0]   enable_lo;
  logic [AXIL_DATA_W-1:0]   enable_hi;
  logic [2*AXIL_DATA_W-1:0] enable_all;

  // Write address and data captured on their own
  logic                     aw_full;
  logic                     w_full;
  logic [AXIL_ADDR_W-1:0]   aw_addr_q;
  logic [AXIL_DATA_W-1:0]   wdata_q;
  logic [AXIL_DATA_W/8-1:0] wstrb_q;
  logic                     wr_commit;

  // Read decode
  logic [AXIL_DATA_W-1:0] rd_data;
  logic [1:0]             rd_resp;

  assign enable_all  = {enable_hi, enable_lo};
  assign enable_mask = enable_all[NUM_STREAMS-1:0];

  // One slot per channel, freed when the write commits
  assign s_axil_awready = !aw_full;
  assign s_axil_wready  = !w_full;
  assign s_axil_arready = !s_axil_rvalid;
  // Commit waits until the previous B has been taken
  assign wr_commit = aw_full && w_full && !s_axil_bvalid;

  // Byte lanes of a write word under strobe
  function automatic logic [AXIL_DATA_W-1:0] apply_strb(
    input logic [AXIL_DATA_W-1:0]   old_val,
    input logic [AXIL_DATA_W-1:0]   new_val,
    input logic [AXIL_DATA_W/8-1:0] strb
  );
    apply_strb = old_val;
    for (int i = 0; i < AXIL_DATA_W/8; i++)
      if (strb[i])
        apply_strb[8*i +: 8] = new_val[8*i +: 8];
  endfunction

  always_ff @(posedge clk) begin
    if (s_axil_awvalid && s_axil_awready)
      aw_addr_q <= s_axil_awaddr;
    if (s_axil_wvalid && s_axil_wready)
    begin
      wdata_q <= s_axil_wdata;
      wstrb_q <= s_axil_wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_full       <= 1'b0;
      w_full        <= 1'b0;
      s_axil_bvalid <= 1'b0;
      s_axil_bresp  <= RESP_OKAY;
      enable_lo     <= '0;
      enable_hi     <= '0;
    end else begin
      if (s_axil_awvalid && s_axil_awready)
        aw_full <= 1'b1;
      if (s_axil_wvalid && s_axil_wready)
        w_full <= 1'b1;
      if (s_axil_bvalid && s_axil_bready)
        s_axil_bvalid <= 1'b0;
      if (wr_commit)
      begin
        aw_full       <= 1'b0;
        w_full        <= 1'b0;
        s_axil_bvalid <= 1'b1;
        s_axil_bresp  <= RESP_OKAY;
        case (aw_addr_q)
          REG_ENABLE_LO: enable_lo <= apply_strb(enable_lo, wdata_q, wstrb_q);
          REG_ENABLE_HI: enable_hi <= apply_strb(enable_hi, wdata_q, wstrb_q);
          // Counters ignore writes
          REG_MATCH_CNT, REG_PKT_CNT: ;
          default: s_axil_bresp <= RESP_SLVERR;
        endcase
      end
    end
  end

  // Counters read back zero extended
  always_comb begin
    rd_resp = RESP_OKAY;
    case (s_axil_araddr)
      REG_ENABLE_LO: rd_data = enable_lo;
      REG_ENABLE_HI: rd_data = enable_hi;
      REG_MATCH_CNT: rd_data = AXIL_DATA_W'(match_count);
      REG_PKT_CNT:   rd_data = AXIL_DATA_W'(pkt_count);
      default:
      begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (s_axil_arvalid && s_axil_arready)
    begin
      s_axil_rdata <= rd_data;
      s_axil_rresp <= rd_resp;
    end
  end

  // R held until rready
  always_ff @(posedge clk) begin
    if (!rst_n)
      s_axil_rvalid <= 1'b0;
    else if (s_axil_arvalid && s_axil_arready)
      s_axil_rvalid <= 1'b1;
    else if (s_axil_rready)
      s_axil_rvalid <= 1'b0;
  end

endmodule

/* logic/csr_pkg.sv */
// AXI4-Lite register map of the scanner
package csr_pkg;

  // Bus widths
  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  // Enable bits for streams 0 to 31, read/write
  localparam logic [AXIL_ADDR_W-1:0] REG_ENABLE_LO = 4'h0;
  // Enable bits for streams 32 to 63, read/write
  localparam logic [AXIL_ADDR_W-1:0] REG_ENABLE_HI = 4'h4;
  // Matched packet count, read only
  localparam logic [AXIL_ADDR_W-1:0] REG_MATCH_CNT = 4'h8;
  // Scanned packet count, read only
  localparam logic [AXIL_ADDR_W-1:0] REG_PKT_CNT   = 4'hC;

  // Response codes on B and R
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* logic/keyword_dfa.sv */
`timescale 1ns/1ps

module keyword_dfa
  import match_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   state_in_vld,
  input  logic [DFA_STATE_W-1:0] state_in,
  input  logic                   char_in_vld,
  input  logic [7:0]             char_in,
  output logic [DFA_STATE_W-1:0] state_out,
  output logic                   accept_out
);

  logic [DFA_STATE_W-1:0] step;
  logic [DFA_STATE_W-1:0] state_next;
  logic                   hit;

  // Keyword byte expected at a given state, none past the end
  function automatic logic kw_match(input logic [DFA_STATE_W-1:0] idx, input logic [7:0] ch);
    kw_match = 1'b0;
    if (int'(idx) < KW_LEN)
      kw_match = (ch == KEYWORD[8*(KW_LEN-1-int'(idx)) +: 8]);
  endfunction

  always_comb begin
    // Keyword has no self overlap, so a mismatch restarts at P or at zero
    if (kw_match(state_out, char_in))
      step = state_out + 1'b1;
    else if (char_in == KW_FIRST)
      step = DFA_STATE_W'(1);
    else
      step = '0;
    hit        = (int'(step) == KW_LEN);
    state_next = step;
    // Full keyword seen, scan on from a fresh start
    if (hit)
      state_next = (char_in == KW_FIRST) ? DFA_STATE_W'(1) : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_out  <= '0;
      accept_out <= 1'b0;
    end else begin
      accept_out <= 1'b0;
      // Restore from saved context wins over scanning
      if (state_in_vld)
        state_out <= state_in;
      else if (char_in_vld)
      begin
        state_out  <= state_next;
        accept_out <= hit;
      end
    end
  end

endmodule

/* logic/match_pkg.sv */
// Constants shared by the byte ingest and the keyword scanner
package match_pkg;

  // Stream id carried on the sop byte
  localparam int STREAM_ID_W = 6;

  // One context slot per possible stream id
  localparam int NUM_STREAMS = 64;

  // DFA state encoding
  // 0 means nothing matched yet, 1..4 count keyword bytes seen
  // 5 is only reached transiently on the accepting byte
  localparam int DFA_STATE_W = 3;

  // Keyword length in bytes
  localparam int KW_LEN = 5;

  // Keyword "PASS " with the first byte in the top 8 bits
  localparam logic [8*KW_LEN-1:0] KEYWORD = {
    8'h50,
    8'h41,
    8'h53,
    8'h53,
    8'h20
  };

  // First keyword byte, used as the restart point on a mismatch
  localparam logic [7:0] KW_FIRST = KEYWORD[8*KW_LEN-1 -: 8];

  // Width of the matched and scanned packet counters
  localparam int CNT_W = 16;

endpackage

/* logic/pop3_scan_top.sv */
`timescale 1ns/1ps

module pop3_scan_top
  import match_pkg::*;
  import csr_pkg::*;
#(
  parameter int NUM_STREAMS = match_pkg::NUM_STREAMS
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // Byte stream
  input  logic                     in_valid,
  input  logic [7:0]               in_data,
  input  logic                     in_sop,
  input  logic                     in_eop,
  input  logic [STREAM_ID_W-1:0]   in_stream_id,
  output logic                     in_ready,
  // Register bus
  input  logic                     s_axil_awvalid,
  input  logic [AXIL_ADDR_W-1:0]   s_axil_awaddr,
  output logic                     s_axil_awready,
  input  logic                     s_axil_wvalid,
  input  logic [AXIL_DATA_W-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_W/8-1:0] s_axil_wstrb,
  output logic                     s_axil_wready,
  output logic                     s_axil_bvalid,
  output logic [1:0]               s_axil_bresp,
  input  logic                     s_axil_bready,
  input  logic                     s_axil_arvalid,
  input  logic [AXIL_ADDR_W-1:0]   s_axil_araddr,
  output logic                     s_axil_arready,
  output logic                     s_axil_rvalid,
  output logic [AXIL_DATA_W-1:0]   s_axil_rdata,
  output logic [1:0]               s_axil_rresp,
  input  logic                     s_axil_rready,
  // Per packet report
  output logic                     pkt_done,
  output logic                     pkt_fired
);

  // Ingest to matcher
  logic                   load_state;
  logic                   load_new;
  logic [STREAM_ID_W-1:0] load_stream_id;
  logic                   char_valid;
  logic [7:0]             char_data;
  logic                   pkt_end;
  // Matcher to and from registers
  logic [NUM_STREAMS-1:0] enable_mask;
  logic [CNT_W-1:0]       match_count;
  logic [CNT_W-1:0]       pkt_count;

  byte_ingest #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_byte_ingest (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_sop         (in_sop),
    .in_eop         (in_eop),
    .in_stream_id   (in_stream_id),
    .in_ready       (in_ready),
    .load_state     (load_state),
    .load_new       (load_new),
    .load_stream_id (load_stream_id),
    .char_valid     (char_valid),
    .char_data      (char_data),
    .pkt_end        (pkt_end)
  );

  stream_context_matcher #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_matcher (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_state     (load_state),
    .load_new       (load_new),
    .load_stream_id (load_stream_id),
    .char_valid     (char_valid),
    .char_data      (char_data),
    .pkt_end        (pkt_end),
    .enable_mask    (enable_mask),
    .match_count    (match_count),
    .pkt_count      (pkt_count),
    .pkt_done       (pkt_done),
    .pkt_fired      (pkt_fired)
  );

  csr_axil #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_csr_axil (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awready (s_axil_awready),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arready (s_axil_arready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rready  (s_axil_rready),
    .match_count    (match_count),
    .pkt_count      (pkt_count),
    .enable_mask    (enable_mask)
  );

endmodule

/* logic/stream_context_matcher.sv */
`timescale 1ns/1ps

module stream_context_matcher
  import match_pkg::*;
#(
  parameter int NUM_STREAMS = match_pkg::NUM_STREAMS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_state,
  input  logic                   load_new,
  input  logic [STREAM_ID_W-1:0] load_stream_id,
  input  logic                   char_valid,
  input  logic [7:0]             char_data,
  input  logic                   pkt_end,
  input  logic [NUM_STREAMS-1:0] enable_mask,
  output logic [CNT_W-1:0]       match_count,
  output logic [CNT_W-1:0]       pkt_count,
  output logic                   pkt_done,
  output logic                   pkt_fired
);

  // Saved DFA state per stream
  logic [DFA_STATE_W-1:0] state_mem [NUM_STREAMS];
  // Stream of the packet in flight
  logic [STREAM_ID_W-1:0] cur_stream;
  // Set on any accept within the current packet
  logic speculative_match;
  logic fired_now;
  logic stream_enabled;

  // Registered DFA inputs
  logic                   state_in_vld_r;
  logic [DFA_STATE_W-1:0] state_in_r;
  logic                   char_in_vld_r;
  logic [7:0]             char_in_r;

  // DFA outputs and their registered copies
  logic [DFA_STATE_W-1:0] state_out;
  logic                   accept_out;
  logic [DFA_STATE_W-1:0] state_out_r;
  logic                   accept_out_r;

  assign stream_enabled = enable_mask[cur_stream];
  // Last byte's accept lands on the pkt_end cycle itself
  assign fired_now = speculative_match || accept_out_r;

  // Context memory, cleared on first use and written back at packet end
  always_ff @(posedge clk) begin
    if (load_state && load_new)
      state_mem[load_stream_id] <= '0;
    else if (pkt_end && stream_enabled)
      state_mem[cur_stream] <= state_out_r;
  end

  // New stream starts from zero, else restore the saved state
  always_ff @(posedge clk) begin
    if (load_state)
    begin
      state_in_r <= load_new ? '0 : state_mem[load_stream_id];
      cur_stream <= load_stream_id;
    end
    char_in_r   <= char_data;
    state_out_r <= state_out;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_in_vld_r <= 1'b0;
      char_in_vld_r  <= 1'b0;
      accept_out_r   <= 1'b0;
    end else begin
      state_in_vld_r <= load_state;
      char_in_vld_r  <= char_valid;
      accept_out_r   <= accept_out;
    end
  end

  keyword_dfa u_keyword_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_in_vld (state_in_vld_r),
    .state_in     (state_in_r),
    .char_in_vld  (char_in_vld_r),
    .char_in      (char_in_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

  // Match flag, counters and packet report
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      speculative_match <= 1'b0;
      match_count       <= '0;
      pkt_count         <= '0;
      pkt_done          <= 1'b0;
      pkt_fired         <= 1'b0;
    end else begin
      pkt_done  <= pkt_end;
      pkt_fired <= 1'b0;
      if (load_state)
        speculative_match <= 1'b0;
      else if (accept_out_r)
        speculative_match <= 1'b1;
      if (pkt_end)
      begin
        // Every finished packet counts as scanned
        pkt_count <= pkt_count + 1'b1;
        // Disabled stream reports no match
        if (stream_enabled)
        begin
          match_count <= match_count + CNT_W'(fired_now);
          pkt_fired   <= fired_now;
        end
      end
    end
  end

endmodule

/* project.f */
logic/match_pkg.sv
logic/csr_pkg.sv
logic/byte_ingest.sv
logic/keyword_dfa.sv
logic/stream_context_matcher.sv
logic/csr_axil.sv
logic/pop3_scan_top.sv
tests/pop3_scan_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scanner testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module pop3_scan_tb \
  --Mdir build \
  -o sim_pop3 \
  -f project.f \
  || { echo "Verilator build failed"; exit 1; }

./build/sim_pop3 > sim.log 2>&1
cat sim.log

# The log decides the verdict
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "No verdict in sim.log"; exit 1; }
exit 0

/* tests/match_cases.txt */
// op_addr_strb_stream_len_offset_nplant_plantbytes_data_flag_stall
// op 1 write, 2 packet, 3 read; data is wdata, filler seed or expected rdata; flag is resp or drop
1_0_F_00_00_00_0_0000000000_000000FF_00_00
1_4_F_00_00_00_0_0000000000_80000001_00_00
3_0_0_00_00_00_0_0000000000_000000FF_00_03
1_4_2_00_00_00_0_0000000000_12345678_00_02
3_4_0_00_00_00_0_0000000000_80005601_00_00
2_0_0_01_0C_04_5_5041535320_00000011_00_00
2_0_0_02_08_00_0_0000000000_00000022_00_00
2_0_0_03_0A_08_2_5041000000_00000033_00_00
2_0_0_06_07_05_2_5041000000_00000044_00_00
2_0_0_02_05_00_0_0000000000_00000055_00_00
2_0_0_03_09_00_3_5353200000_00000066_00_00
2_0_0_05_08_00_3_5353200000_00000077_00_00
2_0_0_14_0A_02_5_5041535320_00000088_00_00
2_0_0_15_06_04_2_5041000000_00000099_00_00
1_0_F_00_00_00_0_0000000000_002000FF_00_00
2_0_0_15_08_00_3_5353200000_000000AA_00_00
2_0_0_20_0E_06_5_5041535320_000000BB_01_00
2_0_0_3F_06_01_5_5041535320_000000CC_00_00
3_8_0_00_00_00_0_0000000000_00000004_00_00
3_C_0_00_00_00_0_0000000000_0000000C_00_02
1_2_F_00_00_00_0_0000000000_DEADBEEF_02_00
3_6_0_00_00_00_0_0000000000_00000000_02_01
3_0_0_00_00_00_0_0000000000_002000FF_00_00

/* tests/pop3_scan_tb.sv */
`timescale 1ns/1ps

module pop3_scan_tb
  import match_pkg::*;
  import csr_pkg::*;
;

  localparam int MAX_CASES = 64;
  localparam logic [31:0] BASE_SEED = 32'h93b3_dd54;
  // Keyword as the scanner should see it
  localparam int KW_CHARS = 5;
  localparam logic [8*KW_CHARS-1:0] KW_TEXT = "PASS ";

  logic clk;
  logic rst_n;
  logic in_valid;
  logic [7:0] in_data;
  logic in_sop;
  logic in_eop;
  logic [STREAM_ID_W-1:0] in_stream_id;
  logic in_ready;
  logic s_axil_awvalid;
  logic [AXIL_ADDR_W-1:0] s_axil_awaddr;
  logic s_axil_awready;
  logic s_axil_wvalid;
  logic [AXIL_DATA_W-1:0] s_axil_wdata;
  logic [AXIL_DATA_W/8-1:0] s_axil_wstrb;
  logic s_axil_wready;
  logic s_axil_bvalid;
  logic [1:0] s_axil_bresp;
  logic s_axil_bready;
  logic s_axil_arvalid;
  logic [AXIL_ADDR_W-1:0] s_axil_araddr;
  logic s_axil_arready;
  logic s_axil_rvalid;
  logic [AXIL_DATA_W-1:0] s_axil_rdata;
  logic [1:0] s_axil_rresp;
  logic s_axil_rready;
  logic pkt_done;
  logic pkt_fired;

  // Case lines and reference model
  logic [127:0] cases [MAX_CASES];
  int num_cases;
  logic [DFA_STATE_W-1:0] model_state [NUM_STREAMS];
  logic [NUM_STREAMS-1:0] model_enable;
  logic [CNT_W-1:0] model_match;
  logic [CNT_W-1:0] model_pkts;
  int value_errors;
  int other_errors;

  pop3_scan_top #(
    .NUM_STREAMS (NUM_STREAMS)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_sop         (in_sop),
    .in_eop         (in_eop),
    .in_stream_id   (in_stream_id),
    .in_ready       (in_ready),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awready (s_axil_awready),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arready (s_axil_arready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rready  (s_axil_rready),
    .pkt_done       (pkt_done),
    .pkt_fired      (pkt_fired)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [7:0] kw_byte(input int i);
    return KW_TEXT[8*(KW_CHARS-1-i) +: 8];
  endfunction

  task automatic check_fired(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [AXIL_DATA_W-1:0] got,
                            input logic [AXIL_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_byte(input logic [7:0] b, input logic sop, input logic eop,
                           input int sid);
    in_valid = 1'b1;
    in_data = b;
    in_sop = sop;
    in_eop = eop;
    in_stream_id = STREAM_ID_W'(sid);
    #1;
    while (!in_ready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int stall, output logic [1:0] resp);
    // Address first, then data, to exercise separate capture
    s_axil_awvalid = 1'b1;
    s_axil_awaddr = addr;
    #1;
    while (!s_axil_awready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #2;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b1;
    s_axil_wdata = data;
    s_axil_wstrb = strb;
    #1;
    while (!s_axil_wready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #2;
    s_axil_wvalid = 1'b0;
    while (!s_axil_bvalid)
    begin
      @(posedge clk);
      #2;
    end
    // B must hold while bready is low
    repeat (stall)
    begin
      @(posedge clk);
      #2;
      if (!s_axil_bvalid)
      begin
        other_errors++;
        $display("Write response was dropped while bready was low at t=%0t", $time);
      end
    end
    resp = s_axil_bresp;
    s_axil_bready = 1'b1;
    @(posedge clk);
    #2;
    s_axil_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    s_axil_arvalid = 1'b1;
    s_axil_araddr = addr;
    #1;
    while (!s_axil_arready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #2;
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid)
    begin
      @(posedge clk);
      #2;
    end
    repeat (stall)
    begin
      @(posedge clk);
      #2;
      if (!s_axil_rvalid)
      begin
        other_errors++;
        $display("Read response was dropped while rready was low at t=%0t", $time);
      end
    end
    data = s_axil_rdata;
    resp = s_axil_rresp;
    s_axil_rready = 1'b1;
    @(posedge clk);
    #2;
    s_axil_rready = 1'b0;
  endtask

  // Builds the packet, predicts the result and drives it
  task automatic run_packet(input logic [127:0] c);
    logic [7:0] bytes [256];
    logic [31:0] rng;
    int sid;
    int len;
    int ofs;
    int n;
    int st;
    int lat;
    logic fired;
    logic exp_fired;
    sid = int'(c[115:108]);
    len = int'(c[107:100]);
    ofs = int'(c[99:92]);
    n = int'(c[91:88]);
    rng = BASE_SEED ^ c[47:16];
    if (rng == 32'h0)
      rng = BASE_SEED;
    for (int i = 0; i < len; i++)
    begin
      if (i >= ofs && i < ofs + n)
        bytes[i] = c[87 - 8*(i-ofs) -: 8];
      else
      begin
        rng = xorshift32(rng);
        // Filler never holds a P, so it cannot start a keyword
        bytes[i] = (rng[7:0] == 8'h50) ? 8'h51 : rng[7:0];
      end
    end
    // Reference model, zero for a stream that never saved a state
    st = int'(model_state[sid]);
    fired = 1'b0;
    for (int i = 0; i < len; i++)
    begin
      if (st < KW_CHARS && bytes[i] == kw_byte(st))
        st = st + 1;
      else if (bytes[i] == 8'h50)
        st = 1;
      else
        st = 0;
      if (st == KW_CHARS)
      begin
        fired = 1'b1;
        st = (bytes[i] == 8'h50) ? 1 : 0;
      end
    end
    exp_fired = fired && model_enable[sid];
    model_pkts = model_pkts + 1'b1;
    if (model_enable[sid])
    begin
      model_state[sid] = DFA_STATE_W'(st);
      model_match = model_match + CNT_W'(fired);
    end
    for (int i = 0; i < len; i++)
    begin
      // Gap in the middle of the packet
      if (c[8] && i > 0 && i == len / 2)
      begin
        in_valid = 1'b0;
        repeat (3) @(posedge clk);
        #2;
      end
      send_byte(bytes[i], i == 0, i == len - 1, sid);
    end
    in_valid = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    // First cycle after the eop byte is already under way
    lat = 1;
    do
    begin
      @(posedge clk);
      #1;
      lat++;
    end while (!pkt_done && lat < 50);
    if (!pkt_done)
    begin
      other_errors++;
      $display("No pkt_done after the packet on stream %0d", sid);
    end
    else
    begin
      if (lat != 4)
      begin
        other_errors++;
        $display("pkt_done came %0d cycles after eop instead of 4, t=%0t", lat, $time);
      end
      check_fired("pkt_fired", pkt_fired, exp_fired);
    end
    #1;
  endtask

  task automatic run_case(input logic [127:0] c);
    logic [AXIL_ADDR_W-1:0] addr;
    logic [31:0] data;
    logic [1:0] resp;
    logic [63:0] word;
    int base;
    addr = c[123:120];
    case (c[127:124])
      4'h1:
      begin
        axi_write(addr, c[47:16], c[119:116], int'(c[7:0]), resp);
        check_resp("s_axil_bresp", resp, c[9:8]);
        if (addr == REG_ENABLE_LO || addr == REG_ENABLE_HI)
        begin
          base = (addr == REG_ENABLE_HI) ? 32 : 0;
          word = 64'(model_enable);
          for (int k = 0; k < 4; k++)
            if (c[116 + k])
              word[base + 8*k +: 8] = c[16 + 8*k +: 8];
          model_enable = NUM_STREAMS'(word);
        end
      end
      4'h2: run_packet(c);
      4'h3:
      begin
        axi_read(addr, int'(c[7:0]), data, resp);
        check_resp("s_axil_rresp", resp, c[9:8]);
        if (addr == REG_MATCH_CNT)
          check_count("match_count", data[CNT_W-1:0], model_match);
        else if (addr == REG_PKT_CNT)
          check_count("pkt_count", data[CNT_W-1:0], model_pkts);
        else
          check_word("s_axil_rdata", data, c[47:16]);
      end
      default:
      begin
        other_errors++;
        $display("Case line has an unknown operation %h", c[127:124]);
      end
    endcase
  endtask

  // Watchdog sized from the number of case lines
  initial
  begin
    int limit;
    #1;
    limit = 200 * num_cases + 1000;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_stream_id = '0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr = '0;
    s_axil_wvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wstrb = '0;
    s_axil_bready = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr = '0;
    s_axil_rready = 1'b0;
    value_errors = 0;
    other_errors = 0;
    model_enable = '0;
    model_match = '0;
    model_pkts = '0;
    for (int i = 0; i < NUM_STREAMS; i++)
    begin
      model_state[i] = '0;
    end
    for (int i = 0; i < MAX_CASES; i++)
      cases[i] = '0;
    $readmemh("tests/match_cases.txt", cases);
    // List ends at the first empty line
    num_cases = 0;
    while (num_cases < MAX_CASES && cases[num_cases][127:124] != 4'h0)
      num_cases++;
    if (num_cases == 0)
    begin
      other_errors++;
      $display("No case lines were read from tests/match_cases.txt");
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < num_cases; i++)
      run_case(cases[i]);
    repeat (4) @(posedge clk);
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
